// ==== hw/cfg_pkg.sv ====
//**************************************************************************
// configuration side types
// register bank contents, filter table requests, read sources
//**************************************************************************
`default_nettype none

`include "cmd_parser_defines.svh"

package cfg_pkg;

    typedef logic [8:0]  threshold_t;   // queue threshold
    typedef logic [7:0]  port_type_t;
    typedef logic [1:0]  cfg_fin_t;
    typedef logic [`CMD_ADDR_HI-`CMD_ADDR_LO:0] reg_addr_t;

    typedef logic [`FLT_AW-1:0] flt_addr_t;
    typedef logic [`FLT_DW-1:0] flt_data_t;

    typedef struct packed {
        cfg_fin_t    cfg_finish;
        port_type_t  port_type;
        logic        qbv_or_qch;
        threshold_t  rc_thr;
        threshold_t  be_thr;
        threshold_t  map_thr;
    } cfg_regs_s;

    typedef struct packed {
        logic        valid;
        reg_addr_t   addr;
        threshold_t  data;    // low bits used for the narrow registers
    } reg_wr_s;

    typedef struct packed {
        logic        valid;
        flt_addr_t   addr;
        flt_data_t   data;
    } flt_wr_s;

    typedef struct packed {
        logic        valid;
        flt_addr_t   addr;
    } flt_rd_s;

    typedef enum logic [2:0] {
        RD_NONE,
        RD_CFG_FINISH,
        RD_PORT_TYPE,
        RD_QBV_QCH,
        RD_RC,
        RD_BE,
        RD_MAP,
        RD_FLT
    } rd_src_e;

    typedef struct packed {
        logic        valid;
        rd_src_e     src;
    } rd_hit_s;

endpackage

`default_nettype wire

// ==== hw/cfg_reg_bank.sv ====
//**************************************************************************
// configuration register bank
// six port registers, loaded by decoded register writes
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "cmd_parser_defines.svh"

module cfg_reg_bank (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire cfg_pkg::reg_wr_s  i_reg_wr,
    output cfg_pkg::cfg_regs_s     o_regs
);

    localparam cfg_pkg::cfg_regs_s REGS_RST = '{
        cfg_finish: '0,
        port_type:  `PORT_TYPE_RST,
        qbv_or_qch: `QBV_QCH_RST,
        rc_thr:     '0,
        be_thr:     '0,
        map_thr:    '0
    };

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_regs <= REGS_RST;
        end else if (i_reg_wr.valid) begin
            case (i_reg_wr.addr)
                `REG_CFG_FINISH: o_regs.cfg_finish <= i_reg_wr.data[1:0];
                `REG_PORT_TYPE:  o_regs.port_type  <= i_reg_wr.data[7:0];
                `REG_QBV_QCH:    o_regs.qbv_or_qch <= i_reg_wr.data[0];
                `REG_RC_THR:     o_regs.rc_thr     <= i_reg_wr.data;
                `REG_BE_THR:     o_regs.be_thr     <= i_reg_wr.data;
                `REG_MAP_THR:    o_regs.map_thr    <= i_reg_wr.data;
                default: ;       // unmapped, ignore
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/cmd_decoder.sv ====
//**************************************************************************
// command decoder
// qualifies write and read commands, registers one-cycle requests
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "cmd_parser_defines.svh"

module cmd_decoder (
    input  wire                        i_clk,
    input  wire                        i_rst_n,
    input  wire                        i_wr_cmd_wr,
    input  wire cmd_fmt_pkg::cmd_word_s i_wr_cmd,
    input  wire                        i_rd_cmd_wr,
    input  wire cmd_fmt_pkg::cmd_word_s i_rd_cmd,
    output cfg_pkg::reg_wr_s           o_reg_wr,
    output cfg_pkg::flt_wr_s           o_flt_wr,
    output cfg_pkg::flt_rd_s           o_flt_rd,
    output cfg_pkg::rd_hit_s           o_reg_rd
);

    logic                 wr_ok;
    logic                 wr_reg;
    logic                 wr_flt;
    logic                 rd_ok;
    logic                 rd_reg;
    logic                 rd_flt;
    cfg_pkg::rd_src_e     rd_src;

    logic                 r_reg_wr_vld;
    logic                 r_flt_wr_vld;
    logic                 r_flt_rd_vld;
    logic                 r_reg_rd_vld;
    cfg_pkg::reg_addr_t   r_reg_waddr;
    cfg_pkg::threshold_t  r_reg_wdata;
    cfg_pkg::flt_addr_t   r_flt_waddr;
    cfg_pkg::flt_data_t   r_flt_wdata;
    cfg_pkg::flt_addr_t   r_flt_raddr;
    cfg_pkg::rd_src_e     r_rd_src;

    // register address to read source
    function automatic cfg_pkg::rd_src_e reg_src(input cmd_fmt_pkg::cmd_addr_t addr);
        case (addr)
            `REG_CFG_FINISH: return cfg_pkg::RD_CFG_FINISH;
            `REG_PORT_TYPE:  return cfg_pkg::RD_PORT_TYPE;
            `REG_QBV_QCH:    return cfg_pkg::RD_QBV_QCH;
            `REG_RC_THR:     return cfg_pkg::RD_RC;
            `REG_BE_THR:     return cfg_pkg::RD_BE;
            `REG_MAP_THR:    return cfg_pkg::RD_MAP;
            default:         return cfg_pkg::RD_NONE;
        endcase
    endfunction

    assign wr_ok  = i_wr_cmd_wr && (i_wr_cmd.cmd_type == cmd_fmt_pkg::CMD_WR);
    assign wr_reg = wr_ok && (i_wr_cmd.tgt == cmd_fmt_pkg::CMD_TGT_REG);
    assign wr_flt = wr_ok && (i_wr_cmd.tgt == cmd_fmt_pkg::CMD_TGT_FLT);

    assign rd_ok  = i_rd_cmd_wr && (i_rd_cmd.cmd_type == cmd_fmt_pkg::CMD_RD);
    assign rd_src = reg_src(i_rd_cmd.addr);
    assign rd_reg = rd_ok && (i_rd_cmd.tgt == cmd_fmt_pkg::CMD_TGT_REG)
                    && (rd_src != cfg_pkg::RD_NONE);
    assign rd_flt = rd_ok && (i_rd_cmd.tgt == cmd_fmt_pkg::CMD_TGT_FLT)
                    && (i_rd_cmd.addr < (cmd_fmt_pkg::cmd_addr_t'(1) << `FLT_AW));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_reg_wr_vld <= 1'b0;
            r_flt_wr_vld <= 1'b0;
            r_flt_rd_vld <= 1'b0;
            r_reg_rd_vld <= 1'b0;
        end else begin
            r_reg_wr_vld <= wr_reg;   // one cycle pulses
            r_flt_wr_vld <= wr_flt;
            r_flt_rd_vld <= rd_flt;
            r_reg_rd_vld <= rd_reg;
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr_reg) begin
            r_reg_waddr <= i_wr_cmd.addr;
            r_reg_wdata <= i_wr_cmd.data[8:0];
        end
        if (wr_flt) begin
            r_flt_waddr <= i_wr_cmd.addr[`FLT_AW-1:0];
            r_flt_wdata <= i_wr_cmd.data[`FLT_DW-1:0];
        end
        if (rd_flt)
            r_flt_raddr <= i_rd_cmd.addr[`FLT_AW-1:0];
        if (rd_reg)
            r_rd_src <= rd_src;
    end

    assign o_reg_wr = '{valid: r_reg_wr_vld, addr: r_reg_waddr, data: r_reg_wdata};
    assign o_flt_wr = '{valid: r_flt_wr_vld, addr: r_flt_waddr, data: r_flt_wdata};
    assign o_flt_rd = '{valid: r_flt_rd_vld, addr: r_flt_raddr};
    assign o_reg_rd = '{valid: r_reg_rd_vld, src: r_rd_src};

    // a read goes either to the bank or to the table
    a_rd_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_flt_rd.valid && o_reg_rd.valid));

endmodule

`default_nettype wire

// ==== hw/cmd_fmt_pkg.sv ====
//**************************************************************************
// command word format
// field types and the 204-bit command / ack word
//**************************************************************************
`default_nettype none

`include "cmd_parser_defines.svh"

package cmd_fmt_pkg;

    typedef logic [`CMD_HDR_HI-`CMD_HDR_LO:0]    cmd_hdr_t;   // passed through untouched
    typedef logic [`CMD_ADDR_HI-`CMD_ADDR_LO:0]  cmd_addr_t;
    typedef logic [`CMD_DATA_HI-`CMD_DATA_LO:0]  cmd_data_t;

    typedef enum logic [`CMD_TGT_HI-`CMD_TGT_LO:0] {
        CMD_TGT_REG = `TGT_REG,
        CMD_TGT_FLT = `TGT_FLT
    } cmd_tgt_e;

    typedef enum logic [`CMD_TYPE_HI-`CMD_TYPE_LO:0] {
        CMD_WR  = `CMD_TYPE_WR,
        CMD_RD  = `CMD_TYPE_RD,
        CMD_ACK = `CMD_TYPE_ACK
    } cmd_type_e;

    // msb first, same layout for write, read and ack
    typedef struct packed {
        cmd_hdr_t   hdr;
        cmd_tgt_e   tgt;
        cmd_type_e  cmd_type;
        cmd_addr_t  addr;
        cmd_data_t  data;
    } cmd_word_s;

endpackage

`default_nettype wire

// ==== hw/cmd_parser_defines.svh ====
//**************************************************************************
// command parser constants
// command word fields, type and target codes, register map, reset values
//**************************************************************************
`ifndef CMD_PARSER_DEFINES_SVH
`define CMD_PARSER_DEFINES_SVH

`define CMD_W           204

// command word fields
`define CMD_HDR_HI      203
`define CMD_HDR_LO      196
`define CMD_TGT_HI      195
`define CMD_TGT_LO      188
`define CMD_TYPE_HI     187
`define CMD_TYPE_LO     184
`define CMD_ADDR_HI     183
`define CMD_ADDR_LO     152
`define CMD_DATA_HI     151
`define CMD_DATA_LO     0

`define CMD_TYPE_WR     4'h1
`define CMD_TYPE_RD     4'h2
`define CMD_TYPE_ACK    4'h6

`define TGT_REG         8'h00
`define TGT_FLT         8'h0c

// register map, target 0
`define REG_CFG_FINISH  32'h3
`define REG_PORT_TYPE   32'h4
`define REG_QBV_QCH     32'h5
`define REG_RC_THR      32'hc
`define REG_BE_THR      32'hd
`define REG_MAP_THR     32'he

`define FLT_AW          14
`define FLT_DW          9

`define PORT_TYPE_RST   8'hff
`define QBV_QCH_RST     1'b1

`endif

// ==== hw/command_parser_top.sv ====
//**************************************************************************
// configuration command parser, top level
// decoder, register bank, filter table port and ack builder
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module command_parser_top (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_wr_command_wr,
    input  wire cmd_fmt_pkg::cmd_word_s iv_wr_command,
    input  wire                         i_rd_command_wr,
    input  wire cmd_fmt_pkg::cmd_word_s iv_rd_command,
    output cmd_fmt_pkg::cmd_word_s      o_rd_command_ack,
    output cfg_pkg::cfg_regs_s          o_cfg_regs,
    output cfg_pkg::flt_addr_t          o_flt_ram_addr,
    output cfg_pkg::flt_data_t          o_flt_ram_wdata,
    output logic                        o_flt_ram_wr,
    output logic                        o_flt_ram_rd,
    input  wire cfg_pkg::flt_data_t     i_flt_ram_rdata
);

    cfg_pkg::reg_wr_s  reg_wr;
    cfg_pkg::flt_wr_s  flt_wr;
    cfg_pkg::flt_rd_s  flt_rd;
    cfg_pkg::rd_hit_s  reg_rd;
    logic              flt_hit;

    cmd_decoder u_cmd_decoder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_wr_cmd_wr (i_wr_command_wr),
        .i_wr_cmd    (iv_wr_command),
        .i_rd_cmd_wr (i_rd_command_wr),
        .i_rd_cmd    (iv_rd_command),
        .o_reg_wr    (reg_wr),
        .o_flt_wr    (flt_wr),
        .o_flt_rd    (flt_rd),
        .o_reg_rd    (reg_rd)
    );

    cfg_reg_bank u_cfg_reg_bank (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_reg_wr (reg_wr),
        .o_regs   (o_cfg_regs)
    );

    flt_table_port u_flt_table_port (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_flt_wr    (flt_wr),
        .i_flt_rd    (flt_rd),
        .o_ram_addr  (o_flt_ram_addr),
        .o_ram_wdata (o_flt_ram_wdata),
        .o_ram_wr    (o_flt_ram_wr),
        .o_ram_rd    (o_flt_ram_rd),
        .o_flt_hit   (flt_hit)
    );

    rd_ack_builder u_rd_ack_builder (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_rd_cmd    (iv_rd_command),
        .i_reg_rd    (reg_rd),
        .i_flt_hit   (flt_hit),
        .i_regs      (o_cfg_regs),
        .i_flt_rdata (i_flt_ram_rdata),
        .o_ack       (o_rd_command_ack)
    );

endmodule

`default_nettype wire

// ==== hw/flt_table_port.sv ====
//**************************************************************************
// filter table RAM port
// write wins over a read in the same cycle and surviving reads are flagged
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module flt_table_port (
    input  wire                    i_clk,
    input  wire                    i_rst_n,
    input  wire cfg_pkg::flt_wr_s  i_flt_wr,
    input  wire cfg_pkg::flt_rd_s  i_flt_rd,
    output cfg_pkg::flt_addr_t     o_ram_addr,
    output cfg_pkg::flt_data_t     o_ram_wdata,
    output logic                   o_ram_wr,
    output logic                   o_ram_rd,
    output logic                   o_flt_hit
);

    //**********************************************************************
    // shared address and read gating
    //**********************************************************************
    assign o_ram_wr    = i_flt_wr.valid;
    assign o_ram_rd    = i_flt_rd.valid && !i_flt_wr.valid;
    assign o_ram_addr  = i_flt_wr.valid ? i_flt_wr.addr : i_flt_rd.addr;
    assign o_ram_wdata = i_flt_wr.data;

    // read reached the RAM, data follows two edges later
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n)
            o_flt_hit <= 1'b0;
        else
            o_flt_hit <= o_ram_rd;
    end

    a_wr_rd_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_ram_wr && o_ram_rd));

endmodule

`default_nettype wire

// ==== hw/rd_ack_builder.sv ====
//**************************************************************************
// read acknowledge builder
// aligns read hits with RAM data and the delayed read header
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

module rd_ack_builder (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire cmd_fmt_pkg::cmd_word_s i_rd_cmd,
    input  wire cfg_pkg::rd_hit_s       i_reg_rd,
    input  wire                         i_flt_hit,
    input  wire cfg_pkg::cfg_regs_s     i_regs,
    input  wire cfg_pkg::flt_data_t     i_flt_rdata,
    output cmd_fmt_pkg::cmd_word_s      o_ack
);

    cfg_pkg::rd_hit_s        r_reg_rd_d;    // lines up with i_flt_hit
    cfg_pkg::rd_hit_s        hit_s1;
    cfg_pkg::rd_hit_s        r_hit_s2;
    cmd_fmt_pkg::cmd_hdr_t   r_hdr_dly  [3];
    cmd_fmt_pkg::cmd_tgt_e   r_tgt_dly  [3];
    cmd_fmt_pkg::cmd_addr_t  r_addr_dly [3];
    cmd_fmt_pkg::cmd_data_t  ack_data;

    //**********************************************************************
    // hit alignment
    //**********************************************************************
    assign hit_s1.valid = r_reg_rd_d.valid || i_flt_hit;
    assign hit_s1.src   = i_flt_hit ? cfg_pkg::RD_FLT : r_reg_rd_d.src;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_reg_rd_d <= '0;
            r_hit_s2   <= '0;
        end else begin
            r_reg_rd_d <= i_reg_rd;
            r_hit_s2   <= hit_s1;
        end
    end

    // header, target and address of the read, three stages
    always_ff @(posedge i_clk) begin
        r_hdr_dly[0]  <= i_rd_cmd.hdr;
        r_tgt_dly[0]  <= i_rd_cmd.tgt;
        r_addr_dly[0] <= i_rd_cmd.addr;
        for (int i = 1; i < 3; i++) begin
            r_hdr_dly[i]  <= r_hdr_dly[i-1];
            r_tgt_dly[i]  <= r_tgt_dly[i-1];
            r_addr_dly[i] <= r_addr_dly[i-1];
        end
    end

    always_comb begin
        case (r_hit_s2.src)
            cfg_pkg::RD_CFG_FINISH: ack_data = cmd_fmt_pkg::cmd_data_t'(i_regs.cfg_finish);
            cfg_pkg::RD_PORT_TYPE:  ack_data = cmd_fmt_pkg::cmd_data_t'(i_regs.port_type);
            cfg_pkg::RD_QBV_QCH:    ack_data = cmd_fmt_pkg::cmd_data_t'(i_regs.qbv_or_qch);
            cfg_pkg::RD_RC:         ack_data = cmd_fmt_pkg::cmd_data_t'(i_regs.rc_thr);
            cfg_pkg::RD_BE:         ack_data = cmd_fmt_pkg::cmd_data_t'(i_regs.be_thr);
            cfg_pkg::RD_MAP:        ack_data = cmd_fmt_pkg::cmd_data_t'(i_regs.map_thr);
            cfg_pkg::RD_FLT:        ack_data = cmd_fmt_pkg::cmd_data_t'(i_flt_rdata);
            default:                ack_data = '0;
        endcase
    end

    // ack keeps its last value between reads
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ack <= '0;
        end else if (r_hit_s2.valid) begin
            o_ack <= '{hdr:      r_hdr_dly[2],
                       tgt:      r_tgt_dly[2],
                       cmd_type: cmd_fmt_pkg::CMD_ACK,
                       addr:     r_addr_dly[2],
                       data:     ack_data};
        end
    end

    // bank read and table read never meet at the merge point
    a_one_src: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(r_reg_rd_d.valid && i_flt_hit));

    a_src_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        r_hit_s2.valid |-> (r_hit_s2.src != cfg_pkg::RD_NONE));

endmodule

`default_nettype wire

// ==== verif/cmd_checker.sv ====
//**************************************************************************
// command parser checker
// reference model of registers, filter table and read acks, compares
// the DUT outputs every cycle
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "cmd_parser_defines.svh"

module cmd_checker (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_wr_cmd_wr,
    input  wire cmd_fmt_pkg::cmd_word_s i_wr_cmd,
    input  wire                         i_rd_cmd_wr,
    input  wire cmd_fmt_pkg::cmd_word_s i_rd_cmd,
    input  wire cmd_fmt_pkg::cmd_word_s i_ack,
    input  wire cfg_pkg::cfg_regs_s     i_regs,
    input  wire cfg_pkg::flt_addr_t     i_ram_addr,
    input  wire cfg_pkg::flt_data_t     i_ram_wdata,
    input  wire                         i_ram_wr,
    input  wire                         i_ram_rd,
    output int                          o_errors,
    output int                          o_checks,
    output int                          o_pending
);

    typedef struct packed {
        int                  due;      // cycle the ack shows up
        logic                is_flt;
        logic [3:0]          sel;
        logic [`CMD_W-1:0]   cmd;
        logic [`FLT_DW-1:0]  flt;
    } pend_s;

    localparam cfg_pkg::cfg_regs_s REGS_RST = '{cfg_finish: 2'd0, port_type: `PORT_TYPE_RST,
        qbv_or_qch: `QBV_QCH_RST, rc_thr: 9'd0, be_thr: 9'd0, map_thr: 9'd0};

    cfg_pkg::flt_data_t  mem [0:(1<<`FLT_AW)-1];
    cfg_pkg::cfg_regs_s  model_regs = REGS_RST;
    cfg_pkg::cfg_regs_s  vis_regs = REGS_RST;    // what o_cfg_regs shows now
    cfg_pkg::cfg_regs_s  reg_hist [8];
    pend_s               pend_q [$];
    pend_s               new_ent;
    pend_s               done_ent;
    int                  cyc = 0;
    logic                exp_wr = 1'b0;
    logic                exp_rd = 1'b0;
    cfg_pkg::flt_addr_t  exp_addr;
    cfg_pkg::flt_data_t  exp_wdata;
    logic [`CMD_W-1:0]   exp_ack = '0;
    logic [8:0]          ack_val;
    logic                wr_ok;
    logic                rd_ok;
    logic                flt_wr;
    logic                flt_rd;
    logic                reg_rd;

    function automatic cfg_pkg::flt_data_t fill_word(input int a);
        return a[8:0] ^ {4'b0, a[13:9]} ^ 9'h0a5;
    endfunction

    function automatic logic reg_known(input logic [31:0] addr);
        case (addr)
            `REG_CFG_FINISH, `REG_PORT_TYPE, `REG_QBV_QCH,
            `REG_RC_THR, `REG_BE_THR, `REG_MAP_THR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [8:0] reg_pick(input cfg_pkg::cfg_regs_s r, input logic [3:0] sel);
        case (sel)
            4'h3: return {7'b0, r.cfg_finish};
            4'h4: return {1'b0, r.port_type};
            4'h5: return {8'b0, r.qbv_or_qch};
            4'hc: return r.rc_thr;
            4'hd: return r.be_thr;
            4'he: return r.map_thr;
            default: return 9'h0;
        endcase
    endfunction

    task automatic apply_reg_write(input logic [31:0] addr, input logic [8:0] d);
        case (addr)
            `REG_CFG_FINISH: model_regs.cfg_finish = d[1:0];
            `REG_PORT_TYPE:  model_regs.port_type  = d[7:0];
            `REG_QBV_QCH:    model_regs.qbv_or_qch = d[0];
            `REG_RC_THR:     model_regs.rc_thr     = d;
            `REG_BE_THR:     model_regs.be_thr     = d;
            `REG_MAP_THR:    model_regs.map_thr    = d;
            default: ;
        endcase
    endtask

    task automatic check_val(input string name, input logic [`CMD_W-1:0] act,
                             input logic [`CMD_W-1:0] exp);
        o_checks++;
        if (act !== exp) begin
            o_errors++;
            $display("ERR %s expected 0x%0h actual 0x%0h at cycle %0d", name, exp, act, cyc);
        end
    endtask

    initial begin
        o_errors  = 0;
        o_checks  = 0;
        o_pending = 0;
        for (int a = 0; a < (1 << `FLT_AW); a++)
            mem[a] = fill_word(a);
        for (int i = 0; i < 8; i++)
            reg_hist[i] = REGS_RST;
    end

    //**********************************************************************
    // model update at the edge where the DUT samples the commands
    //**********************************************************************
    always @(posedge i_clk) begin
        if (!i_rst_n) begin
            cyc        = 0;
            model_regs = REGS_RST;
            vis_regs   = REGS_RST;
            exp_wr     = 1'b0;
            exp_rd     = 1'b0;
            exp_ack    = '0;
            pend_q.delete();
        end else begin
            cyc++;
            vis_regs = model_regs;            // writes show one edge late
            reg_hist[cyc % 8] = vis_regs;
            wr_ok  = i_wr_cmd_wr && (i_wr_cmd.cmd_type == `CMD_TYPE_WR);
            rd_ok  = i_rd_cmd_wr && (i_rd_cmd.cmd_type == `CMD_TYPE_RD);
            flt_wr = wr_ok && (i_wr_cmd.tgt == `TGT_FLT);
            flt_rd = rd_ok && (i_rd_cmd.tgt == `TGT_FLT) && (i_rd_cmd.addr <= 32'h3fff);
            reg_rd = rd_ok && (i_rd_cmd.tgt == `TGT_REG) && reg_known(i_rd_cmd.addr);
            exp_wr    = flt_wr;
            exp_rd    = flt_rd && !flt_wr;    // write wins
            exp_addr  = flt_wr ? i_wr_cmd.addr[`FLT_AW-1:0] : i_rd_cmd.addr[`FLT_AW-1:0];
            exp_wdata = i_wr_cmd.data[`FLT_DW-1:0];
            if (reg_rd || exp_rd) begin
                new_ent.due    = cyc + 3;
                new_ent.is_flt = exp_rd;
                new_ent.sel    = i_rd_cmd.addr[3:0];
                new_ent.cmd    = i_rd_cmd;
                new_ent.flt    = mem[i_rd_cmd.addr[`FLT_AW-1:0]];
                pend_q.push_back(new_ent);
            end
            if (flt_wr)
                mem[i_wr_cmd.addr[`FLT_AW-1:0]] = i_wr_cmd.data[`FLT_DW-1:0];
            if (wr_ok && (i_wr_cmd.tgt == `TGT_REG))
                apply_reg_write(i_wr_cmd.addr, i_wr_cmd.data[8:0]);
        end
        o_pending = pend_q.size();
    end

    // outputs are settled mid cycle
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            check_val("o_flt_ram_wr", i_ram_wr, exp_wr);
            check_val("o_flt_ram_rd", i_ram_rd, exp_rd);
            if (exp_wr || exp_rd)
                check_val("o_flt_ram_addr", i_ram_addr, exp_addr);
            if (exp_wr)
                check_val("o_flt_ram_wdata", i_ram_wdata, exp_wdata);
            check_val("o_cfg_regs", i_regs, vis_regs);
            if (pend_q.size() > 0 && pend_q[0].due == cyc) begin
                done_ent = pend_q.pop_front();
                ack_val  = done_ent.is_flt ? done_ent.flt
                         : reg_pick(reg_hist[(done_ent.due - 1) % 8], done_ent.sel);
                exp_ack  = {done_ent.cmd[`CMD_HDR_HI:`CMD_TGT_LO], `CMD_TYPE_ACK,
                            done_ent.cmd[`CMD_ADDR_HI:`CMD_ADDR_LO],
                            {(`CMD_DATA_HI-8){1'b0}}, ack_val};
            end
            check_val("o_rd_command_ack", i_ack, exp_ack);   // holds between acks
            o_pending = pend_q.size();
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_command_parser.sv ====
//**************************************************************************
// command parser testbench
// clock, reset, filter RAM model and seeded random commands
//**************************************************************************
`timescale 1ns/1ns
`default_nettype none

`include "cmd_parser_defines.svh"

module tb_command_parser;

    localparam int N_CMDS        = 2000;
    localparam int RST_TIMEOUT   = 20;
    localparam int DRAIN_TIMEOUT = 40;

    logic                    clk;
    logic                    rst_n;
    logic                    wr_stb;
    logic                    rd_stb;
    cmd_fmt_pkg::cmd_word_s  wr_cmd;
    cmd_fmt_pkg::cmd_word_s  rd_cmd;
    cmd_fmt_pkg::cmd_word_s  ack;
    cfg_pkg::cfg_regs_s      cfg_regs;
    cfg_pkg::flt_addr_t      ram_addr;
    cfg_pkg::flt_data_t      ram_wdata;
    logic                    ram_wr;
    logic                    ram_rd;
    cfg_pkg::flt_data_t      ram_rdata = '0;
    cfg_pkg::flt_data_t      ram_rd_d1 = '0;
    cfg_pkg::flt_data_t      ram [0:(1<<`FLT_AW)-1];
    int                      errors;
    int                      checks;
    int                      pending;
    int                      seed;
    bit                      ok;
    bit                      aborted;

    command_parser_top DUT (
        .i_clk            (clk),
        .i_rst_n          (rst_n),
        .i_wr_command_wr  (wr_stb),
        .iv_wr_command    (wr_cmd),
        .i_rd_command_wr  (rd_stb),
        .iv_rd_command    (rd_cmd),
        .o_rd_command_ack (ack),
        .o_cfg_regs       (cfg_regs),
        .o_flt_ram_addr   (ram_addr),
        .o_flt_ram_wdata  (ram_wdata),
        .o_flt_ram_wr     (ram_wr),
        .o_flt_ram_rd     (ram_rd),
        .i_flt_ram_rdata  (ram_rdata)
    );

    cmd_checker u_checker (
        .i_clk       (clk),
        .i_rst_n     (rst_n),
        .i_wr_cmd_wr (wr_stb),
        .i_wr_cmd    (wr_cmd),
        .i_rd_cmd_wr (rd_stb),
        .i_rd_cmd    (rd_cmd),
        .i_ack       (ack),
        .i_regs      (cfg_regs),
        .i_ram_addr  (ram_addr),
        .i_ram_wdata (ram_wdata),
        .i_ram_wr    (ram_wr),
        .i_ram_rd    (ram_rd),
        .o_errors    (errors),
        .o_checks    (checks),
        .o_pending   (pending)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //**********************************************************************
    // filter RAM, data two edges after the read strobe
    //**********************************************************************
    function automatic cfg_pkg::flt_data_t fill_word(input int a);
        return a[8:0] ^ {4'b0, a[13:9]} ^ 9'h0a5;
    endfunction

    initial begin
        for (int a = 0; a < (1 << `FLT_AW); a++)
            ram[a] = fill_word(a);
    end

    always @(posedge clk) begin
        if (ram_wr)
            ram[ram_addr] <= ram_wdata;
        if (ram_rd)
            ram_rd_d1 <= ram[ram_addr];
        ram_rdata <= ram_rd_d1;
    end

    function automatic logic [31:0] reg_addr_pick();
        logic [31:0] r;
        r = $urandom;
        case (r[2:0])
            3'd0: return `REG_CFG_FINISH;
            3'd1: return `REG_PORT_TYPE;
            3'd2: return `REG_QBV_QCH;
            3'd3: return `REG_RC_THR;
            3'd4: return `REG_BE_THR;
            3'd5: return `REG_MAP_THR;
            default: return {28'h0, r[7:4]};   // often unmapped
        endcase
    endfunction

    // valid or broken command of the given type
    function automatic cmd_fmt_pkg::cmd_word_s rand_cmd(input logic [3:0] good_type);
        logic [31:0]  r;
        logic [31:0]  r_hdr;
        logic [3:0]   typ;
        logic [7:0]   tgt;
        logic [31:0]  addr;
        logic [159:0] data;
        r     = $urandom;
        r_hdr = $urandom;
        typ   = (r[3:0] < 4'd12) ? good_type : r[7:4];
        if (r[10:8] < 3'd3) begin
            tgt  = `TGT_REG;
            addr = reg_addr_pick();
        end else if (r[10:8] < 3'd7) begin
            tgt  = `TGT_FLT;
            addr = (r[15:12] == 4'd0) ? ({16'h0, r[31:16]} | 32'h4000) : {27'h0, r[20:16]};
        end else begin
            tgt  = r[23:16];
            addr = {28'h0, r[27:24]};
        end
        data = {$urandom, $urandom, $urandom, $urandom, $urandom};
        return cmd_fmt_pkg::cmd_word_s'({r_hdr[7:0], tgt, typ, addr, data[151:0]});
    endfunction

    task automatic wait_reset_done(output bit done);
        int n;
        n    = 0;
        done = 1'b0;
        while (!done && n < RST_TIMEOUT) begin
            @(negedge clk);
            n++;
            done = rst_n && (cfg_regs.port_type === `PORT_TYPE_RST)
                   && (cfg_regs.qbv_or_qch === `QBV_QCH_RST)
                   && (ram_wr === 1'b0) && (ram_rd === 1'b0) && (ack === '0);
        end
    endtask

    task automatic run_stimulus();
        logic [31:0] r;
        repeat (N_CMDS) begin
            @(negedge clk);
            r      = $urandom;
            wr_stb = (r[1:0] != 2'b00);
            rd_stb = (r[3:2] != 2'b00);
            wr_cmd = rand_cmd(`CMD_TYPE_WR);
            rd_cmd = rand_cmd(`CMD_TYPE_RD);
        end
        @(negedge clk);
        wr_stb = 1'b0;
        rd_stb = 1'b0;
    endtask

    task automatic wait_acks_drained(output bit done);
        int n;
        n = 0;
        while (pending != 0 && n < DRAIN_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        done = (pending == 0);
    endtask

    initial begin
        rst_n   = 1'b0;
        wr_stb  = 1'b0;
        rd_stb  = 1'b0;
        wr_cmd  = '0;
        rd_cmd  = '0;
        aborted = 1'b0;
        seed    = 36100;
        void'($urandom(seed));
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        wait_reset_done(ok);
        if (!ok) begin
            $display("timeout: DUT outputs never reached their reset state");
            aborted = 1'b1;
        end else begin
            run_stimulus();
            wait_acks_drained(ok);
            if (!ok) begin
                $display("timeout: %0d read acks never arrived", pending);
                aborted = 1'b1;
            end
        end
        repeat (3) @(negedge clk);
        @(posedge clk);
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0 && !aborted)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hw
hw/cmd_fmt_pkg.sv
hw/cfg_pkg.sv
hw/cmd_decoder.sv
hw/cfg_reg_bank.sv
hw/flt_table_port.sv
hw/rd_ack_builder.sv
hw/command_parser_top.sv
verif/cmd_checker.sv
verif/tb_command_parser.sv
